/* hw/evo_xb_pkg.sv */
/*
 * Shared CSR types, address map and info ROM for the Evo extension block.
 * CSR data and address are 8 bits; a port register window spans five offsets.
 * Port bases must not overlap each other or the two info addresses.
 */

package evo_xb_pkg;

   // ------------------------------------------------------------------------
   // Bus widths and base types
   // ------------------------------------------------------------------------

   localparam int CSR_DWIDTH = 8;
   localparam int MADR_WIDTH = 8;

   // One CSR data word
   typedef logic [CSR_DWIDTH-1:0] csr_data_t;
   // One CSR byte address
   typedef logic [MADR_WIDTH-1:0] csr_addr_t;

   // Avalon request as seen by every slave, 18 bits in total
   typedef struct packed {
      csr_addr_t addr;
      logic      rd;
      logic      wr;
      csr_data_t wdata;
   } csr_req_t;

   // ------------------------------------------------------------------------
   // Address map
   // ------------------------------------------------------------------------

   // Offsets inside one port window
   localparam csr_addr_t PMUX_OFS_WRADR = 8'd0;
   localparam csr_addr_t PMUX_OFS_DIR   = 8'd1;
   localparam csr_addr_t PMUX_OFS_OUT   = 8'd2;
   localparam csr_addr_t PMUX_OFS_EN    = 8'd3;
   localparam csr_addr_t PMUX_OFS_IN    = 8'd4;

   // Port window bases
   localparam csr_addr_t PMUX_D_BASE = 8'h10;
   localparam csr_addr_t PMUX_E_BASE = 8'h18;

   // Indirect info window
   localparam csr_addr_t XB_INFO_IDX_ADDR  = 8'h00;
   localparam csr_addr_t XB_INFO_DATA_ADDR = 8'h01;

   // ------------------------------------------------------------------------
   // Information ROM
   // ------------------------------------------------------------------------

   localparam int XB_INFO_COUNT = 4;

   // Entry 0 block id, 1 major rev, 2 minor rev, 3 number of ports
   localparam csr_data_t XB_INFO_ROM [XB_INFO_COUNT] = '{
      8'hE5,
      8'h01,
      8'h00,
      8'h02
   };

endpackage : evo_xb_pkg

/* hw/evo_xb_info.sv */
/*
 * Read-only info registers behind an index/data pair.
 * Every data read advances the index and wraps after the last ROM entry.
 */

`timescale 1ns/1ps

module evo_xb_info (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  evo_xb_pkg::csr_req_t  csr_req_i,
   output evo_xb_pkg::csr_data_t rd_data_o
);

   import evo_xb_pkg::*;

   localparam int IDX_W = $clog2(XB_INFO_COUNT);

   // Index into the info ROM
   typedef logic [IDX_W-1:0] info_idx_t;

   localparam info_idx_t IDX_LAST = info_idx_t'(XB_INFO_COUNT - 1);

   info_idx_t idx_q;
   logic      idx_wr;
   logic      data_rd;
   logic      idx_rd;

   // ------------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------------

   assign idx_wr  = csr_req_i.wr && (csr_req_i.addr == XB_INFO_IDX_ADDR);
   assign idx_rd  = csr_req_i.rd && (csr_req_i.addr == XB_INFO_IDX_ADDR);
   assign data_rd = csr_req_i.rd && (csr_req_i.addr == XB_INFO_DATA_ADDR);

   // Index register
   // Load from low write-data bits, step after each data read
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         idx_q <= '0;
      end else if (idx_wr) begin
         idx_q <= csr_req_i.wdata[IDX_W-1:0];
      end else if (data_rd) begin
         // Wrap back to the first entry
         idx_q <= (idx_q == IDX_LAST) ? '0 : idx_q + 1'b1;
      end
   end

   // Read mux, returns the entry before the increment
   always_comb begin
      rd_data_o = '0;
      if (data_rd) begin
         rd_data_o = XB_INFO_ROM[idx_q];
      end else if (idx_rd) begin
         rd_data_o = csr_data_t'(idx_q);
      end
   end

endmodule : evo_xb_info

/* hw/evo_pmux_csr.sv */
/*
 * Per-port control registers for MUX_WIDTH sources, selected through WRADR.
 * PORT_DWIDTH must not exceed the CSR data width; upper write bits are dropped.
 * Source s drives bits [s*PORT_DWIDTH +: PORT_DWIDTH] of each output bus.
 */

`timescale 1ns/1ps

module evo_pmux_csr #(
   parameter int                    PORT_DWIDTH = 8,
   parameter int                    MUX_WIDTH   = 4,
   parameter evo_xb_pkg::csr_addr_t PMUX_BASE   = 8'h10
) (
   input  logic                             clk,
   input  logic                             arst_n_i,
   input  evo_xb_pkg::csr_req_t             csr_req_i,
   input  logic [PORT_DWIDTH-1:0]           pmux_in_i,
   output evo_xb_pkg::csr_data_t            rd_data_o,
   output logic [PORT_DWIDTH*MUX_WIDTH-1:0] pmux_dir_o,
   output logic [PORT_DWIDTH*MUX_WIDTH-1:0] pmux_out_o,
   output logic [PORT_DWIDTH*MUX_WIDTH-1:0] pmux_en_o
);

   import evo_xb_pkg::*;

   // Source select needs at least one bit
   localparam int SEL_W = (MUX_WIDTH > 1) ? $clog2(MUX_WIDTH) : 1;

   // Absolute register addresses of this port
   localparam csr_addr_t ADR_WRADR = PMUX_BASE + PMUX_OFS_WRADR;
   localparam csr_addr_t ADR_DIR   = PMUX_BASE + PMUX_OFS_DIR;
   localparam csr_addr_t ADR_OUT   = PMUX_BASE + PMUX_OFS_OUT;
   localparam csr_addr_t ADR_EN    = PMUX_BASE + PMUX_OFS_EN;
   localparam csr_addr_t ADR_IN    = PMUX_BASE + PMUX_OFS_IN;

   // One value per pin of the port
   typedef logic [PORT_DWIDTH-1:0] pin_vec_t;
   // Source number
   typedef logic [SEL_W-1:0] src_sel_t;

   src_sel_t                  sel_q;
   pin_vec_t [MUX_WIDTH-1:0]  dir_q;
   pin_vec_t [MUX_WIDTH-1:0]  out_q;
   pin_vec_t [MUX_WIDTH-1:0]  en_q;
   pin_vec_t                  wr_pins;

   // Only the pin-wide part of the write data is kept
   assign wr_pins = csr_req_i.wdata[PORT_DWIDTH-1:0];

   // ------------------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sel_q <= '0;
         dir_q <= '0;
         out_q <= '0;
         en_q  <= '0;
      end else if (csr_req_i.wr) begin
         case (csr_req_i.addr)
            // Source number wraps modulo MUX_WIDTH
            ADR_WRADR: sel_q <= src_sel_t'(csr_req_i.wdata % MUX_WIDTH);
            ADR_DIR:   dir_q[sel_q] <= wr_pins;
            ADR_OUT:   out_q[sel_q] <= wr_pins;
            ADR_EN:    en_q[sel_q]  <= wr_pins;
            default: ;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // Read mux
   // ------------------------------------------------------------------------

   // Zero unless this port's window is being read
   always_comb begin
      rd_data_o = '0;
      if (csr_req_i.rd) begin
         case (csr_req_i.addr)
            ADR_WRADR: rd_data_o = csr_data_t'(sel_q);
            ADR_DIR:   rd_data_o = csr_data_t'(dir_q[sel_q]);
            ADR_OUT:   rd_data_o = csr_data_t'(out_q[sel_q]);
            ADR_EN:    rd_data_o = csr_data_t'(en_q[sel_q]);
            // Live pin state, sampled with the read
            ADR_IN:    rd_data_o = csr_data_t'(pmux_in_i);
            default:   rd_data_o = '0;
         endcase
      end
   end

   // Flatten per-source registers onto the mux buses
   assign pmux_dir_o = dir_q;
   assign pmux_out_o = out_q;
   assign pmux_en_o  = en_q;

endmodule : evo_pmux_csr

/* hw/evo_xb_pmux.sv */
/*
 * Wired-OR pin mux for one port, each source gated by its own enable.
 * Only one source should enable a pin; overlapping sources are ORed.
 */

`timescale 1ns/1ps

module evo_xb_pmux #(
   parameter int PORT_DWIDTH = 8,
   parameter int MUX_WIDTH   = 4
) (
   input  logic [PORT_DWIDTH*MUX_WIDTH-1:0] src_dir_i,
   input  logic [PORT_DWIDTH*MUX_WIDTH-1:0] src_out_i,
   input  logic [PORT_DWIDTH*MUX_WIDTH-1:0] src_en_i,
   output logic [PORT_DWIDTH-1:0]           dir_o,
   output logic [PORT_DWIDTH-1:0]           out_o,
   output logic [PORT_DWIDTH-1:0]           en_o
);

   // Per-source slice of each bus
   logic [PORT_DWIDTH-1:0] src_en;

   // ------------------------------------------------------------------------
   // OR over all sources
   // ------------------------------------------------------------------------

   always_comb begin
      dir_o = '0;
      out_o = '0;
      en_o  = '0;
      for (int s = 0; s < MUX_WIDTH; s++) begin
         src_en = src_en_i[s*PORT_DWIDTH +: PORT_DWIDTH];
         // A pin is driven if any source claims it
         en_o  = en_o | src_en;
         // Disabled sources contribute nothing
         dir_o = dir_o | (src_dir_i[s*PORT_DWIDTH +: PORT_DWIDTH] & src_en);
         out_o = out_o | (src_out_i[s*PORT_DWIDTH +: PORT_DWIDTH] & src_en);
      end
   end

endmodule : evo_xb_pmux

/* hw/evo_csr_resp.sv */
/*
 * Avalon read response: ORs slave read data and registers it with valid.
 * Slaves must return zero when not addressed; no waitrequest is produced.
 */

`timescale 1ns/1ps

module evo_csr_resp (
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  logic                  rd_req_i,
   input  evo_xb_pkg::csr_data_t info_data_i,
   input  evo_xb_pkg::csr_data_t pmux_d_data_i,
   input  evo_xb_pkg::csr_data_t pmux_e_data_i,
   output logic                  readdatavalid_o,
   output evo_xb_pkg::csr_data_t readdata_o
);

   import evo_xb_pkg::*;

   // Combined read data of all slaves
   csr_data_t merged;

   // Unmapped addresses give zero here
   assign merged = info_data_i | pmux_d_data_i | pmux_e_data_i;

   // ------------------------------------------------------------------------
   // Response register
   // ------------------------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         readdatavalid_o <= 1'b0;
         readdata_o      <= '0;
      end else begin
         // Valid for exactly the cycle after the strobe
         readdatavalid_o <= rd_req_i;
         // Data held at zero between responses
         readdata_o      <= rd_req_i ? merged : '0;
      end
   end

endmodule : evo_csr_resp

/* hw/evo_xb.sv */
/*
 * Evo extension block top: info window plus ports D and E on one CSR bus.
 * Master must not overlap requests; reads answer exactly one cycle later.
 * Port widths must not exceed the 8-bit CSR data width.
 */

`timescale 1ns/1ps

module evo_xb #(
   parameter int PORT_D_DWIDTH = 8,
   parameter int PORT_E_DWIDTH = 6
) (
   input  logic                     clk,
   input  logic                     arst_n_i,
   // CSR bus, Avalon MM slave
   input  evo_xb_pkg::csr_req_t     csr_req_i,
   output logic                     readdatavalid_o,
   output evo_xb_pkg::csr_data_t    readdata_o,
   // Port D pins
   input  logic [PORT_D_DWIDTH-1:0] port_d_in_i,
   output logic [PORT_D_DWIDTH-1:0] port_d_dir_o,
   output logic [PORT_D_DWIDTH-1:0] port_d_out_o,
   output logic [PORT_D_DWIDTH-1:0] port_d_en_o,
   // Port E pins
   input  logic [PORT_E_DWIDTH-1:0] port_e_in_i,
   output logic [PORT_E_DWIDTH-1:0] port_e_dir_o,
   output logic [PORT_E_DWIDTH-1:0] port_e_out_o,
   output logic [PORT_E_DWIDTH-1:0] port_e_en_o
);

   import evo_xb_pkg::*;

   // Sources that may drive any one pin
   localparam int PMUX_WIDTH = 4;

   // Read data from each slave, zero when not addressed
   csr_data_t info_rd_data;
   csr_data_t pmux_d_rd_data;
   csr_data_t pmux_e_rd_data;

   // Per-source pin controls, one port-wide slice per source
   logic [PORT_D_DWIDTH*PMUX_WIDTH-1:0] port_d_src_dir;
   logic [PORT_D_DWIDTH*PMUX_WIDTH-1:0] port_d_src_out;
   logic [PORT_D_DWIDTH*PMUX_WIDTH-1:0] port_d_src_en;
   logic [PORT_E_DWIDTH*PMUX_WIDTH-1:0] port_e_src_dir;
   logic [PORT_E_DWIDTH*PMUX_WIDTH-1:0] port_e_src_out;
   logic [PORT_E_DWIDTH*PMUX_WIDTH-1:0] port_e_src_en;

   // ------------------------------------------------------------------------
   // CSR slaves
   // ------------------------------------------------------------------------

   evo_xb_info evo_xb_info_i (
      .clk       (clk),
      .arst_n_i  (arst_n_i),
      .csr_req_i (csr_req_i),
      .rd_data_o (info_rd_data)
   );

   evo_pmux_csr #(
      .PORT_DWIDTH (PORT_D_DWIDTH),
      .MUX_WIDTH   (PMUX_WIDTH),
      .PMUX_BASE   (PMUX_D_BASE)
   ) evo_pmux_csr_d_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .csr_req_i  (csr_req_i),
      .pmux_in_i  (port_d_in_i),
      .rd_data_o  (pmux_d_rd_data),
      .pmux_dir_o (port_d_src_dir),
      .pmux_out_o (port_d_src_out),
      .pmux_en_o  (port_d_src_en)
   );

   evo_pmux_csr #(
      .PORT_DWIDTH (PORT_E_DWIDTH),
      .MUX_WIDTH   (PMUX_WIDTH),
      .PMUX_BASE   (PMUX_E_BASE)
   ) evo_pmux_csr_e_i (
      .clk        (clk),
      .arst_n_i   (arst_n_i),
      .csr_req_i  (csr_req_i),
      .pmux_in_i  (port_e_in_i),
      .rd_data_o  (pmux_e_rd_data),
      .pmux_dir_o (port_e_src_dir),
      .pmux_out_o (port_e_src_out),
      .pmux_en_o  (port_e_src_en)
   );

   // ------------------------------------------------------------------------
   // Pin multiplexers, one per port
   // ------------------------------------------------------------------------

   evo_xb_pmux #(
      .PORT_DWIDTH (PORT_D_DWIDTH),
      .MUX_WIDTH   (PMUX_WIDTH)
   ) evo_xb_pmux_d_i (
      .src_dir_i (port_d_src_dir),
      .src_out_i (port_d_src_out),
      .src_en_i  (port_d_src_en),
      .dir_o     (port_d_dir_o),
      .out_o     (port_d_out_o),
      .en_o      (port_d_en_o)
   );

   evo_xb_pmux #(
      .PORT_DWIDTH (PORT_E_DWIDTH),
      .MUX_WIDTH   (PMUX_WIDTH)
   ) evo_xb_pmux_e_i (
      .src_dir_i (port_e_src_dir),
      .src_out_i (port_e_src_out),
      .src_en_i  (port_e_src_en),
      .dir_o     (port_e_dir_o),
      .out_o     (port_e_out_o),
      .en_o      (port_e_en_o)
   );

   // Read response, one cycle after the strobe
   evo_csr_resp evo_csr_resp_i (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .rd_req_i        (csr_req_i.rd),
      .info_data_i     (info_rd_data),
      .pmux_d_data_i   (pmux_d_rd_data),
      .pmux_e_data_i   (pmux_e_rd_data),
      .readdatavalid_o (readdatavalid_o),
      .readdata_o      (readdata_o)
   );

endmodule : evo_xb

/* tests/evo_xb_tb_util.svh */
/*
 * Testbench helpers, included inside the testbench module body.
 * Bus tasks drive csr_req on falling edges; one request at a time.
 */

`ifndef EVO_XB_TB_UTIL_SVH
`define EVO_XB_TB_UTIL_SVH

// Cycles allowed between read strobe and readdatavalid_o
localparam int RESP_TIMEOUT = 16;

// Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_state = 32'h186bee86;

// One LFSR step per bit taken, newest bit at the bottom
function automatic csr_data_t rand_bits(input int nbits);
   csr_data_t value;
   logic      fb;
   value = '0;
   for (int i = 0; i < nbits; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      value = {value[CSR_DWIDTH-2:0], fb};
   end
   return value;
endfunction

// Single-cycle write strobe
task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
   @(negedge clk);
   csr_req = '{addr: addr, rd: 1'b0, wr: 1'b1, wdata: data};
   @(negedge clk);
   csr_req = '0;
endtask

// Single-cycle read strobe, then wait for the response
task automatic csr_read(input csr_addr_t addr, output csr_data_t data);
   int cycles;
   @(negedge clk);
   csr_req = '{addr: addr, rd: 1'b1, wr: 1'b0, wdata: '0};
   @(negedge clk);
   csr_req = '0;
   cycles = 0;
   while (!readdatavalid_o && cycles < RESP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
   end
   if (!readdatavalid_o) begin
      report_failure($sformatf("No read response for address 0x%02h", addr));
   end else begin
      data = readdata_o;
   end
endtask

`endif

/* tests/evo_xb_tb.sv */
/*
 * Testbench for the Evo extension block, ports D (8 pins) and E (6 pins).
 * Stops at the first failed check; random values come from a fixed-seed LFSR.
 */

`timescale 1ns/1ps

module evo_xb_tb;

   import evo_xb_pkg::*;

   localparam int PORT_D_DWIDTH = 8;
   localparam int PORT_E_DWIDTH = 6;
   localparam int NUM_SRC       = 4;

   logic                     clk;
   logic                     arst_n;
   csr_req_t                 csr_req;
   logic                     readdatavalid_o;
   csr_data_t                readdata_o;
   logic [PORT_D_DWIDTH-1:0] port_d_in;
   logic [PORT_D_DWIDTH-1:0] port_d_dir_o;
   logic [PORT_D_DWIDTH-1:0] port_d_out_o;
   logic [PORT_D_DWIDTH-1:0] port_d_en_o;
   logic [PORT_E_DWIDTH-1:0] port_e_in;
   logic [PORT_E_DWIDTH-1:0] port_e_dir_o;
   logic [PORT_E_DWIDTH-1:0] port_e_out_o;
   logic [PORT_E_DWIDTH-1:0] port_e_en_o;

   // Testbench copies of the per-source registers
   // Index 0 is port D and index 1 is port E
   csr_data_t m_dir [2][NUM_SRC];
   csr_data_t m_out [2][NUM_SRC];
   csr_data_t m_en  [2][NUM_SRC];
   csr_data_t rdata;

   evo_xb #(
      .PORT_D_DWIDTH (PORT_D_DWIDTH),
      .PORT_E_DWIDTH (PORT_E_DWIDTH)
   ) evo_xb_i (
      .clk             (clk),
      .arst_n_i        (arst_n),
      .csr_req_i       (csr_req),
      .readdatavalid_o (readdatavalid_o),
      .readdata_o      (readdata_o),
      .port_d_in_i     (port_d_in),
      .port_d_dir_o    (port_d_dir_o),
      .port_d_out_o    (port_d_out_o),
      .port_d_en_o     (port_d_en_o),
      .port_e_in_i     (port_e_in),
      .port_e_dir_o    (port_e_dir_o),
      .port_e_out_o    (port_e_out_o),
      .port_e_en_o     (port_e_en_o)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input csr_data_t got, input csr_data_t exp);
      assert (got === exp) else
         report_failure($sformatf("Mismatch at %0t: %s got 0x%02h expected 0x%02h",
                                  $time, name, got, exp));
   endtask

   `include "evo_xb_tb_util.svh"

   // Response comes in exactly the cycle after each read strobe
   valid_follows_read: assert property (@(posedge clk) disable iff (!arst_n)
      readdatavalid_o == $past(csr_req.rd))
      else report_failure($sformatf("Mismatch at %0t: readdatavalid_o got %b expected %b",
                                    $time, $sampled(readdatavalid_o),
                                    !$sampled(readdatavalid_o)));

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Port helpers
   // ------------------------------------------------------------------------

   function automatic csr_addr_t port_base(input int p);
      return (p == 0) ? PMUX_D_BASE : PMUX_E_BASE;
   endfunction

   function automatic csr_data_t port_mask(input int p);
      return (p == 0) ? 8'hFF : 8'h3F;
   endfunction

   // Random DIR, OUT and EN for every source of one port
   task automatic fill_port(input int p);
      csr_addr_t base;
      base = port_base(p);
      for (int s = 0; s < NUM_SRC; s++) begin
         csr_write(base + PMUX_OFS_WRADR, csr_data_t'(s));
         m_dir[p][s] = rand_bits(8);
         csr_write(base + PMUX_OFS_DIR, m_dir[p][s]);
         m_out[p][s] = rand_bits(8);
         csr_write(base + PMUX_OFS_OUT, m_out[p][s]);
         m_en[p][s] = rand_bits(8);
         csr_write(base + PMUX_OFS_EN, m_en[p][s]);
      end
   endtask

   // Readback of every source of one port
   // Source number is written with an offset of NUM_SRC to hit the wrap
   task automatic verify_port(input int p);
      csr_addr_t base;
      csr_data_t mask;
      base = port_base(p);
      mask = port_mask(p);
      for (int s = 0; s < NUM_SRC; s++) begin
         csr_write(base + PMUX_OFS_WRADR, csr_data_t'(s + NUM_SRC));
         csr_read(base + PMUX_OFS_WRADR, rdata);
         check_eq($sformatf("port %0d WRADR", p), rdata, csr_data_t'(s));
         csr_read(base + PMUX_OFS_DIR, rdata);
         check_eq($sformatf("port %0d DIR src %0d", p, s), rdata, m_dir[p][s] & mask);
         csr_read(base + PMUX_OFS_OUT, rdata);
         check_eq($sformatf("port %0d OUT src %0d", p, s), rdata, m_out[p][s] & mask);
         csr_read(base + PMUX_OFS_EN, rdata);
         check_eq($sformatf("port %0d EN src %0d", p, s), rdata, m_en[p][s] & mask);
      end
   endtask

   // Pin outputs against the OR-with-enable rule
   task automatic check_pins(input int p);
      csr_data_t exp_dir;
      csr_data_t exp_out;
      csr_data_t exp_en;
      exp_dir = '0;
      exp_out = '0;
      exp_en  = '0;
      for (int s = 0; s < NUM_SRC; s++) begin
         exp_en  = exp_en | m_en[p][s];
         exp_dir = exp_dir | (m_dir[p][s] & m_en[p][s]);
         exp_out = exp_out | (m_out[p][s] & m_en[p][s]);
      end
      if (p == 0) begin
         check_eq("port_d_en_o", port_d_en_o, exp_en);
         check_eq("port_d_dir_o", port_d_dir_o, exp_dir);
         check_eq("port_d_out_o", port_d_out_o, exp_out);
      end else begin
         check_eq("port_e_en_o", csr_data_t'(port_e_en_o), exp_en & 8'h3F);
         check_eq("port_e_dir_o", csr_data_t'(port_e_dir_o), exp_dir & 8'h3F);
         check_eq("port_e_out_o", csr_data_t'(port_e_out_o), exp_out & 8'h3F);
      end
   endtask

   // ------------------------------------------------------------------------
   // Test sequence
   // ------------------------------------------------------------------------

   initial begin
      arst_n    = 1'b0;
      csr_req   = '0;
      port_d_in = '0;
      port_e_in = '0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Reset state
      check_eq("port_d_en_o", port_d_en_o, 8'h00);
      check_eq("port_e_en_o", csr_data_t'(port_e_en_o), 8'h00);
      check_eq("readdatavalid_o", csr_data_t'(readdatavalid_o), 8'h00);

      // Unmapped address reads as zero
      csr_read(8'h40, rdata);
      check_eq("readdata_o unmapped", rdata, 8'h00);

      repeat (2) begin
         fill_port(0);
         fill_port(1);
         check_pins(0);
         check_pins(1);
         verify_port(0);
         verify_port(1);
      end

      // Live pin inputs read back zero-extended
      repeat (4) begin
         @(negedge clk);
         port_d_in = rand_bits(PORT_D_DWIDTH);
         port_e_in = rand_bits(PORT_E_DWIDTH);
         csr_read(PMUX_D_BASE + PMUX_OFS_IN, rdata);
         check_eq("port D IN", rdata, csr_data_t'(port_d_in));
         csr_read(PMUX_E_BASE + PMUX_OFS_IN, rdata);
         check_eq("port E IN", rdata, csr_data_t'(port_e_in));
      end

      // Info window walks the ROM and wraps
      csr_write(XB_INFO_IDX_ADDR, 8'h00);
      for (int i = 0; i < 5; i++) begin
         csr_read(XB_INFO_DATA_ADDR, rdata);
         check_eq($sformatf("info entry %0d", i), rdata, XB_INFO_ROM[i % XB_INFO_COUNT]);
      end
      csr_read(XB_INFO_IDX_ADDR, rdata);
      check_eq("info index", rdata, 8'h01);

      $display("all tests passed");
      $finish;
   end

endmodule : evo_xb_tb

/* list.f */
+incdir+tests
hw/evo_xb_pkg.sv
hw/evo_xb_info.sv
hw/evo_pmux_csr.sv
hw/evo_xb_pmux.sv
hw/evo_csr_resp.sv
hw/evo_xb.sv
tests/evo_xb_tb.sv
